// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

   localparam int DATA_W = 32;   // word size, fixed by the encoding

   // special registers
   localparam logic [3:0] REG_LINK = 4'd14;
   localparam logic [3:0] REG_PC   = 4'd15;

   // bit positions in the 4-bit flag word
   localparam int FLAG_C = 0;
   localparam int FLAG_Z = 1;
   localparam int FLAG_S = 2;
   localparam int FLAG_V = 3;

   // instruction class in bits 27..25, class 3 does nothing
   typedef enum logic [2:0] {
      ALU_REG = 3'd0,
      ALU_IMM = 3'd1,
      CALL    = 3'd2,
      ST_REG  = 3'd4,
      LD_REG  = 3'd5,
      ST_IMM  = 3'd6,
      LD_IMM  = 3'd7
   } cpu_class_e;

   // two-register alu operation in bits 3..0
   typedef enum logic [3:0] {
      ADD = 4'd0,
      SUB = 4'd1,
      AND = 4'd2,
      OR  = 4'd3,
      XOR = 4'd4,
      SHL = 4'd5,
      SHR = 4'd6,
      MOV = 4'd7,
      CMP = 4'd8   // sub, flags only
   } alu_op_e;

   // condition field in bits 31..28
   typedef enum logic [3:0] {
      AL, EQ, NE, CS, CC, MI, PL, VS, VC, HI, LS, GE, LT, GT, LE, NV
   } cond_e;

endpackage

// ==== verilog/cpu_sched.sv ====
module cpu_sched
(
   input  logic       clk,
   input  logic       rst_i,
   output logic       phf_o,
   output logic       phe_o,
   output logic       phm_o,
   output logic       phw_o,
   output logic [2:0] clk_stat_o
);

   logic [1:0] phase;   // 0 fetch .. 3 writeback
   logic       run;     // set one cycle after reset drops

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         run   <= 1'b0;
         phase <= 2'd0;
      end
      else
      begin
         run <= 1'b1;
         if (run)
            phase <= phase + 2'd1;   // wraps after writeback
      end
   end

   assign phf_o = run & (phase == 2'd0);
   assign phe_o = run & (phase == 2'd1);
   assign phm_o = run & (phase == 2'd2);
   assign phw_o = run & (phase == 2'd3);

   assign clk_stat_o = {run, phase};

endmodule

// ==== verilog/cpu_regfile.sv ====
module cpu_regfile
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              rst_i,
   input  logic [3:0]        ra_i,
   input  logic [3:0]        rb_i,
   input  logic [3:0]        rd_i,
   input  logic [3:0]        rw_i,
   input  logic [3:0]        rt_i,
   input  logic              inc_pc_i,
   input  logic              link_i,
   input  logic              base_wb_i,
   input  logic              wb_i,
   input  logic [DATA_W-1:0] wb_data_i,
   input  logic [DATA_W-1:0] base_data_i,
   output logic [DATA_W-1:0] da_o,
   output logic [DATA_W-1:0] db_o,
   output logic [DATA_W-1:0] dd_o,
   output logic [DATA_W-1:0] dt_o,
   output logic [DATA_W-1:0] pc_o
);

   logic [DATA_W-1:0] regs [16];   // r15 is the program counter

   // later statements win when strobes hit the same register
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < 16; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         if (inc_pc_i)
            regs[REG_PC] <= regs[REG_PC] + 1'b1;   // word addressed
         if (link_i)
            regs[REG_LINK] <= regs[REG_PC];   // return address
         if (base_wb_i)
            regs[ra_i] <= base_data_i;
         if (wb_i)
            regs[rw_i] <= wb_data_i;   // also a jump when rw_i is r15
      end
   end

   // operand reads
   assign da_o = regs[ra_i];
   assign db_o = regs[rb_i];
   assign dd_o = regs[rd_i];

   // test port and pc
   assign dt_o = regs[rt_i];
   assign pc_o = regs[REG_PC];

endmodule

// ==== verilog/cpu_alu.sv ====
module cpu_alu
   import cpu_pkg::*;
(
   input  alu_op_e           op_i,
   input  logic [DATA_W-1:0] a_i,
   input  logic [DATA_W-1:0] b_i,
   input  logic [3:0]        flags_i,
   output logic [DATA_W-1:0] res_o,
   output logic [3:0]        flags_o,
   output logic              wb_en_o
);

   logic [DATA_W:0] sum;    // carry out on top
   logic [DATA_W:0] diff;   // top bit set when no borrow
   logic [DATA_W:0] shl;    // bit shifted out on top
   logic [DATA_W:0] shr;    // bit shifted out at bottom
   logic [4:0]      sh;
   logic            c;
   logic            v;

   assign sh   = b_i[4:0];
   assign sum  = {1'b0, a_i} + {1'b0, b_i};
   assign diff = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;
   assign shl  = {1'b0, a_i} << sh;
   assign shr  = {a_i, 1'b0} >> sh;

   always_comb
   begin
      res_o   = '0;
      c       = flags_i[FLAG_C];   // kept unless the op defines it
      v       = flags_i[FLAG_V];
      wb_en_o = 1'b1;
      case (op_i)
         ADD:
         begin
            res_o = sum[DATA_W-1:0];
            c     = sum[DATA_W];
            v     = (a_i[DATA_W-1] == b_i[DATA_W-1]) && (sum[DATA_W-1] != a_i[DATA_W-1]);
         end
         SUB, CMP:
         begin
            res_o   = diff[DATA_W-1:0];
            c       = diff[DATA_W];
            v       = (a_i[DATA_W-1] != b_i[DATA_W-1]) && (diff[DATA_W-1] != a_i[DATA_W-1]);
            wb_en_o = (op_i != CMP);
         end
         AND:
            res_o = a_i & b_i;
         OR:
            res_o = a_i | b_i;
         XOR:
            res_o = a_i ^ b_i;
         SHL:
         begin
            res_o = shl[DATA_W-1:0];
            if (sh != 5'd0)
               c = shl[DATA_W];
         end
         SHR:
         begin
            res_o = shr[DATA_W:1];
            if (sh != 5'd0)
               c = shr[0];
         end
         MOV:
            res_o = b_i;
         default:
            wb_en_o = 1'b0;   // unused codes write nothing
      endcase

      flags_o         = '0;
      flags_o[FLAG_C] = c;
      flags_o[FLAG_Z] = (res_o == '0);
      flags_o[FLAG_S] = res_o[DATA_W-1];
      flags_o[FLAG_V] = v;
   end

endmodule

// ==== verilog/cpu_core.sv ====
module cpu_core
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              rst_i,
   input  logic [DATA_W-1:0] bus_rdata_i,
   input  logic [3:0]        rt_i,
   output logic [DATA_W-1:0] bus_addr_o,
   output logic [DATA_W-1:0] bus_wdata_o,
   output logic              bus_we_o,
   output logic [DATA_W-1:0] dt_o,
   output logic [2:0]        clk_stat_o
);

   logic              phf, phe, phm, phw;   // phase strobes
   logic [DATA_W-1:0] ir;        // instruction register
   logic [3:0]        flags;
   logic [DATA_W-1:0] ld_data;   // word latched in phm
   logic [DATA_W-1:0] da, db, dd, pc;
   logic [DATA_W-1:0] imm_sx;
   logic [DATA_W-1:0] ea;
   logic [DATA_W-1:0] call_tgt;
   logic [DATA_W-1:0] wb_data;
   logic [DATA_W-1:0] alu_b, alu_res;
   logic [3:0]        alu_flags;
   logic              alu_wb;
   alu_op_e           alu_op;
   cpu_class_e        cls;
   cond_e             cond;
   logic              ena;       // condition holds
   logic              is_alu_reg, is_alu_imm, is_alu, is_call, is_ld, is_st, is_mem;
   logic              do_wb, is_jump;
   logic [3:0]        rw;

   cpu_sched sched (
      .clk        (clk),
      .rst_i      (rst_i),
      .phf_o      (phf),
      .phe_o      (phe),
      .phm_o      (phm),
      .phw_o      (phw),
      .clk_stat_o (clk_stat_o)
   );

   always_ff @(posedge clk)
   begin
      if (rst_i)
         ir <= '0;
      else if (phf)
         ir <= bus_rdata_i;
   end

   // instruction fields
   assign cls    = cpu_class_e'(ir[27:25]);
   assign cond   = cond_e'(ir[31:28]);
   assign imm_sx = {{16{ir[15]}}, ir[15:0]};

   assign is_alu_reg = (cls == ALU_REG);
   assign is_alu_imm = (cls == ALU_IMM);
   assign is_alu     = is_alu_reg | is_alu_imm;
   assign is_call    = (cls == CALL);
   assign is_ld      = (cls == LD_REG) | (cls == LD_IMM);
   assign is_st      = (cls == ST_REG) | (cls == ST_IMM);
   assign is_mem     = is_ld | is_st;

   always_comb
   begin
      case (cond)
         EQ: ena = flags[FLAG_Z];
         NE: ena = ~flags[FLAG_Z];
         CS: ena = flags[FLAG_C];
         CC: ena = ~flags[FLAG_C];
         MI: ena = flags[FLAG_S];
         PL: ena = ~flags[FLAG_S];
         VS: ena = flags[FLAG_V];
         VC: ena = ~flags[FLAG_V];
         HI: ena = flags[FLAG_C] & ~flags[FLAG_Z];
         LS: ena = ~flags[FLAG_C] | flags[FLAG_Z];
         GE: ena = ~(flags[FLAG_S] ^ flags[FLAG_V]);
         LT: ena = flags[FLAG_S] ^ flags[FLAG_V];
         GT: ena = ~flags[FLAG_Z] & ~(flags[FLAG_S] ^ flags[FLAG_V]);
         LE: ena = flags[FLAG_Z] | (flags[FLAG_S] ^ flags[FLAG_V]);
         default: ena = 1'b1;   // AL and NV
      endcase
   end

   // immediate form: bit 24 picks add over move
   assign alu_op = is_alu_imm ? (ir[24] ? ADD : MOV) : alu_op_e'(ir[3:0]);
   assign alu_b  = is_alu_imm ? imm_sx : db;

   cpu_alu alu (
      .op_i    (alu_op),
      .a_i     (da),
      .b_i     (alu_b),
      .flags_i (flags),
      .res_o   (alu_res),
      .flags_o (alu_flags),
      .wb_en_o (alu_wb)
   );

   always_ff @(posedge clk)
   begin
      if (rst_i)
         flags <= '0;
      else if (phw && ena && is_alu_reg && ir[24])
         flags <= alu_flags;
   end

   // effective address, classes 6 and 7 use the immediate
   assign ea = da + (ir[26] ? imm_sx : db);

   assign call_tgt = ir[24] ? dd + {{12{ir[19]}}, ir[19:0]} : {8'd0, ir[23:0]};

   assign wb_data = is_call ? call_tgt : is_ld ? ld_data : alu_res;
   assign do_wb   = (is_alu & alu_wb) | is_call | is_ld;
   assign is_jump = is_call | (((is_alu & alu_wb) | is_ld) & (ir[23:20] == REG_PC));
   assign rw      = is_call ? REG_PC : ir[23:20];

   cpu_regfile regs (
      .clk         (clk),
      .rst_i       (rst_i),
      .ra_i        (ir[19:16]),
      .rb_i        (ir[15:12]),
      .rd_i        (ir[23:20]),
      .rw_i        (rw),
      .rt_i        (rt_i),
      .inc_pc_i    (phe),
      .link_i      (phm & ena & is_call),
      .base_wb_i   (phm & ena & is_mem & ir[24]),
      .wb_i        (phw & ena & do_wb),
      .wb_data_i   (wb_data),
      .base_data_i (ea),
      .da_o        (da),
      .db_o        (db),
      .dd_o        (dd),
      .dt_o        (dt_o),
      .pc_o        (pc)
   );

   always_ff @(posedge clk)
   begin
      if (phm && is_ld)
         ld_data <= bus_rdata_i;
   end

   always_comb
   begin
      bus_addr_o = pc;   // fetch and skipped instructions
      if (ena)
      begin
         if ((phe || phm) && is_mem)
            bus_addr_o = ea;
         else if (phw && is_jump)
            bus_addr_o = wb_data;   // jump target
      end
   end

   assign bus_wdata_o = dd;
   assign bus_we_o    = phm & ena & is_st;

endmodule

// ==== verilog/cpu_mem.sv ====
module cpu_mem
   import cpu_pkg::*;
#(
   parameter int MEM_AW = 10
)
(
   input  logic              clk,
   input  logic [DATA_W-1:0] addr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic              we_i,
   output logic [DATA_W-1:0] rdata_o,
   input  logic              load_we_i,
   input  logic [MEM_AW-1:0] load_addr_i,
   input  logic [DATA_W-1:0] load_data_i,
   output logic [DATA_W-1:0] load_rdata_o
);

   logic [DATA_W-1:0] mem [2**MEM_AW];   // program and data
   logic [MEM_AW-1:0] core_addr;

   // core addresses wrap at the array size
   assign core_addr = addr_i[MEM_AW-1:0];

   always_ff @(posedge clk)
   begin
      if (load_we_i)
         mem[load_addr_i] <= load_data_i;   // load port first
      else if (we_i)
         mem[core_addr] <= wdata_i;
   end

   // both reads are combinational
   assign rdata_o      = mem[core_addr];
   assign load_rdata_o = mem[load_addr_i];

endmodule

// ==== verilog/cpu_system.sv ====
module cpu_system
   import cpu_pkg::*;
#(
   parameter int MEM_AW = 10
)
(
   input  logic              clk,
   input  logic              rst_i,
   input  logic              load_we_i,
   input  logic [MEM_AW-1:0] load_addr_i,
   input  logic [DATA_W-1:0] load_data_i,
   output logic [DATA_W-1:0] load_rdata_o,
   input  logic [3:0]        test_rsel_i,
   output logic [DATA_W-1:0] test_reg_o,
   output logic [2:0]        clk_stat_o
);

   // core to memory bus
   logic [DATA_W-1:0] bus_addr;
   logic [DATA_W-1:0] bus_wdata;
   logic [DATA_W-1:0] bus_rdata;
   logic              bus_we;

   cpu_core core (
      .clk         (clk),
      .rst_i       (rst_i),
      .bus_rdata_i (bus_rdata),
      .rt_i        (test_rsel_i),
      .bus_addr_o  (bus_addr),
      .bus_wdata_o (bus_wdata),
      .bus_we_o    (bus_we),
      .dt_o        (test_reg_o),
      .clk_stat_o  (clk_stat_o)
   );

   cpu_mem #(.MEM_AW(MEM_AW)) memory (
      .clk          (clk),
      .addr_i       (bus_addr),
      .wdata_i      (bus_wdata),
      .we_i         (bus_we),
      .rdata_o      (bus_rdata),
      .load_we_i    (load_we_i),
      .load_addr_i  (load_addr_i),
      .load_data_i  (load_data_i),
      .load_rdata_o (load_rdata_o)
   );

endmodule

// ==== bench/cpu_chk.sv ====
module cpu_chk
(
   input logic clk,
   input logic rst_i,
   input logic phf_i,
   input logic phe_i,
   input logic phm_i,
   input logic phw_i,
   input logic bus_we_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // one cycle of settling after reset before the phases run
   a_onehot: assert property (@(posedge clk)
      (!rst_i && !$past(rst_i)) |-> $onehot({phf_i, phe_i, phm_i, phw_i}))
      else $error("phase strobes not one-hot");

   a_reset: assert property (@(posedge clk)
      (rst_i && $past(rst_i)) |-> ({phf_i, phe_i, phm_i, phw_i} == 4'b0000))
      else $error("phase strobe active in reset");

   a_order: assert property (@(posedge clk) disable iff (rst_i) phw_i |=> phf_i)
      else $error("fetch does not follow writeback");

   a_we: assert property (@(posedge clk) bus_we_i |-> $past(phe_i))   // store right after execute
      else $error("bus write outside memory phase");

endmodule

bind cpu_core cpu_chk chk
(
   .clk      (clk),
   .rst_i    (rst_i),
   .phf_i    (phf),
   .phe_i    (phe),
   .phm_i    (phm),
   .phw_i    (phw),
   .bus_we_i (bus_we_o)
);

// ==== bench/cpu_tb.sv ====
module cpu_tb
   import cpu_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic        clk, rst_i, load_we_i;
   logic [9:0]  load_addr_i;
   logic [31:0] load_data_i, load_rdata_o, test_reg_o;
   logic [3:0]  test_rsel_i;
   logic [2:0]  clk_stat_o;

   logic [31:0] img [1024];     // program image loaded before each run
   logic [31:0] m_mem [1024];   // reference model state
   logic [31:0] m_r [16];
   logic [3:0]  m_flags;
   int          wp, errs, n_pass, n_fail;

   cpu_system #(.MEM_AW(10)) uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] enc(input int cond, input int cls, input int b24,
                                       input int rd, input int ra, input int lo);
      return {cond[3:0], cls[2:0], b24[0], rd[3:0], ra[3:0], lo[15:0]};
   endfunction

   function automatic logic [31:0] alu_r(input int op, input int rd, input int ra,
                                         input int rb, input int s);
      return enc(0, 0, s, rd, ra, {rb[3:0], 8'h00, op[3:0]});
   endfunction

   task automatic new_prog();
      for (int a = 0; a < 1024; a++)
         img[a] = (a * 32'h9e37_79b1) ^ 32'h0f0f_0000;   // unique per address
      wp = 0;
   endtask

   task automatic emit(input logic [31:0] w);
      img[wp] = w;
      wp++;
   endtask

   // hi16 << 16 plus sign-extended lo16 via scratch r12
   task automatic put_const(input int rd, input logic [31:0] val);
      logic [15:0] hi;
      hi = val[31:16] + val[15];
      emit(enc(0, 1, 0, rd, 0, hi));
      emit(enc(0, 1, 0, 12, 0, 16));
      emit(alu_r(5, rd, rd, 12, 0));
      emit(enc(0, 1, 1, rd, rd, val[15:0]));
   endtask

   task automatic halt();
      emit(enc(0, 1, 0, 15, 0, wp));   // mov r15 to itself
   endtask

   function automatic void cpu_model_step();
      logic [31:0] ir, a, b, res, imm, ea, d;
      logic [3:0]  rd, ra, rb, op;
      logic        c, z, s, v, ok;
      ir = m_mem[m_r[15][9:0]];
      m_r[15] = m_r[15] + 1;
      {v, s, z, c} = {m_flags[FLAG_V], m_flags[FLAG_S], m_flags[FLAG_Z], m_flags[FLAG_C]};
      case (cond_e'(ir[31:28]))
         EQ: ok = z;
         NE: ok = !z;
         CS: ok = c;
         CC: ok = !c;
         MI: ok = s;
         PL: ok = !s;
         VS: ok = v;
         VC: ok = !v;
         HI: ok = c && !z;
         LS: ok = !c || z;
         GE: ok = (s == v);
         LT: ok = (s != v);
         GT: ok = !z && (s == v);
         LE: ok = z || (s != v);
         default: ok = 1'b1;
      endcase
      if (!ok)
         return;
      rd  = ir[23:20];
      ra  = ir[19:16];
      rb  = ir[15:12];
      op  = ir[3:0];
      imm = {{16{ir[15]}}, ir[15:0]};
      case (ir[27:25])
         3'd0:
         begin
            a = m_r[ra];
            b = m_r[rb];
            case (op)
               4'd0:
               begin
                  res = a + b;
                  c   = (res < a);
                  v   = (a[31] == b[31]) && (res[31] != a[31]);
               end
               4'd1, 4'd8:
               begin
                  res = a - b;
                  c   = (a >= b);
                  v   = (a[31] != b[31]) && (res[31] != a[31]);
               end
               4'd2: res = a & b;
               4'd3: res = a | b;
               4'd4: res = a ^ b;
               4'd5:
               begin
                  res = a << b[4:0];
                  if (b[4:0] != 0)
                     c = a[32 - b[4:0]];
               end
               4'd6:
               begin
                  res = a >> b[4:0];
                  if (b[4:0] != 0)
                     c = a[b[4:0] - 1];
               end
               default: res = b;
            endcase
            if (op != 4'd8)
               m_r[rd] = res;
            if (ir[24])
               m_flags = {v, res[31], (res == 0), c};   // V S Z C
         end
         3'd1: m_r[rd] = ir[24] ? m_r[ra] + imm : imm;
         3'd2:
         begin
            m_r[14] = m_r[15];   // link before the indexed target is read
            m_r[15] = ir[24] ? m_r[rd] + {{12{ir[19]}}, ir[19:0]} : {8'd0, ir[23:0]};
         end
         3'd4, 3'd5, 3'd6, 3'd7:
         begin
            ea = m_r[ra] + (ir[26] ? imm : m_r[rb]);
            d  = m_r[rd];
            if (ir[24])
               m_r[ra] = ea;
            if (ir[25])
               m_r[rd] = m_mem[ea[9:0]];
            else
               m_mem[ea[9:0]] = d;
         end
         default: ;   // class 3 no-op
      endcase
   endfunction

   // pc first, read while the core still sits in fetch
   task automatic check_regs(input bit zero);
      logic [31:0] exp;
      int          r;
      for (int i = 0; i < 16; i++)
      begin
         r = (i + 15) % 16;
         test_rsel_i = r;
         @(posedge clk);
         exp = zero ? 32'd0 : m_r[r];
         if (test_reg_o !== exp)
         begin
            $display("ERR %0t r%0d expected %h got %h", $time, r, exp, test_reg_o);
            errs++;
         end
         @(negedge clk);
      end
   endtask

   task automatic wait_phase(input logic [1:0] p, output int t);
      t = 0;
      do
      begin
         @(negedge clk);
         t++;
      end
      while (clk_stat_o !== {1'b1, p} && t < 40);
      if (clk_stat_o !== {1'b1, p})
         t = -1;
   endtask

   task automatic run_test(input string name, input int steps);
      int t;
      errs  = 0;
      rst_i = 1'b1;
      repeat (3) @(negedge clk);
      if (clk_stat_o[2] !== 1'b0)
      begin
         $display("ERR %0t status running in reset", $time);
         errs++;
      end
      check_regs(1);
      for (int a = 0; a < 1024; a++)
      begin
         @(negedge clk);
         load_we_i   = 1'b1;
         load_addr_i = a;
         load_data_i = img[a];
         m_mem[a]    = img[a];
      end
      @(negedge clk);
      load_we_i = 1'b0;
      foreach (m_r[i])
         m_r[i] = '0;
      m_flags = '0;
      repeat (steps) cpu_model_step();
      rst_i = 1'b0;
      wait_phase(2'd0, t);
      if (t < 0)
      begin
         $display("%s: the phase counter never ran", name);
         errs++;
      end
      else
      begin
         if (t != 1)
         begin
            $display("ERR %0t fetch came %0d cycles after reset", $time, t);
            errs++;
         end
         for (int k = 1; k <= 4 * steps; k++)
         begin
            @(negedge clk);
            if (clk_stat_o !== {1'b1, k[1:0]})
            begin
               $display("ERR %0t phase expected %0d got %b", $time, k % 4, clk_stat_o);
               errs++;
            end
         end
         check_regs(0);   // starts in the fetch of the halt loop
      end
      rst_i = 1'b1;
      @(negedge clk);
      for (int a = 0; a < 1024; a++)
      begin
         load_addr_i = a;
         @(posedge clk);
         if (load_rdata_o !== m_mem[a])
         begin
            $display("ERR %0t mem[%0d] expected %h got %h", $time, a, m_mem[a], load_rdata_o);
            errs++;
         end
         @(negedge clk);
      end
      if (errs == 0)
         n_pass++;
      else
         n_fail++;
      $display("%s: %s, %0d errors", name, (errs == 0) ? "pass" : "fail", errs);
   endtask

   initial
   begin
      logic [31:0] pa [5];
      logic [31:0] pb [5];
      int          kind, rd;
      void'($urandom(54031));
      rst_i       = 1'b1;
      load_we_i   = 1'b0;
      load_addr_i = '0;
      load_data_i = '0;
      test_rsel_i = '0;
      n_pass      = 0;
      n_fail      = 0;

      new_prog();
      emit(enc(0, 1, 0, 1, 0, 5));
      halt();
      run_test("reset and phases", 4);

      repeat (2)
      begin
         new_prog();
         put_const(1, $urandom);
         put_const(2, $urandom);
         emit(enc(0, 1, 0, 13, 0, 600));
         for (int op = 0; op < 9; op++)
         begin
            emit(alu_r(op, 3 + op, 1, 2, 1));
            emit(enc(0, 1, 0, 0, 0, 0));   // r0 gathers C Z S V
            emit(enc(3, 1, 1, 0, 0, 1));
            emit(enc(1, 1, 1, 0, 0, 2));
            emit(enc(5, 1, 1, 0, 0, 4));
            emit(enc(7, 1, 1, 0, 0, 8));
            emit(enc(0, 6, 0, 0, 13, 16 + op));
         end
         for (int k = 0; k < 9; k++)
            emit(enc(0, 6, 0, 3 + k, 13, k));
         halt();
         run_test("alu operations", wp + 2);
      end

      pa = '{32'd5, 32'd3, 32'd7, 32'h7fff_ffff, 32'h8000_0000};
      pb = '{32'd5, 32'd7, 32'd3, 32'hffff_ffff, $urandom};
      new_prog();
      emit(enc(0, 1, 0, 13, 0, 640));
      for (int p = 0; p < 5; p++)
      begin
         put_const(1, pa[p]);
         put_const(2, pb[p]);
         emit(enc(0, 1, 0, 3, 0, 0));
         emit(alu_r(8, 0, 1, 2, 1));   // compare sets flags
         for (int c = 0; c < 16; c++)
            emit(enc(c, 1, 1, 3, 3, 1 << c));   // one bit per condition
         emit(enc(0, 6, 0, 3, 13, p));
      end
      halt();
      run_test("condition codes", wp + 2);

      new_prog();
      put_const(1, 520 + $urandom % 40);
      put_const(2, 560 + $urandom % 40);
      for (int r = 3; r < 6; r++)
         emit(enc(0, 1, 0, r, 0, $urandom % 16));
      for (int r = 6; r < 12; r++)
         put_const(r, $urandom);
      repeat (16)
      begin
         kind = 4 + $urandom % 4;   // store or load with register or immediate offset
         emit(enc(0, kind, $urandom % 2, 6 + $urandom % 6, 1 + $urandom % 2,
                  kind[1] ? ($urandom % 17) - 8 : (3 + $urandom % 3) << 12));
      end
      halt();
      run_test("loads and stores", wp + 2);

      new_prog();
      emit(enc(0, 1, 0, 8, 0, 60));
      emit(enc(0, 1, 0, 5, 0, 50));
      emit(enc(0, 2, 0, 0, 0, 20));   // absolute call
      wp = 20;
      emit(alu_r(7, 6, 0, 14, 0));   // return address of the absolute call
      emit(enc(0, 2, 1, 5, 4'hf, 16'hfff9));   // r5 minus 7
      wp = 43;
      emit(alu_r(7, 7, 0, 14, 0));
      emit(alu_r(7, 15, 0, 8, 0));   // jump through r15
      emit(enc(0, 1, 0, 9, 0, 1));
      wp = 60;
      emit(enc(0, 1, 0, 10, 0, 10));
      halt();
      run_test("calls and jumps", 11);

      new_prog();
      emit(enc(0, 1, 0, 1, 0, 520));
      emit(enc(0, 1, 0, 2, 0, 600));
      emit(enc(0, 1, 0, 3, 0, 680));
      for (int r = 4; r < 12; r++)
         put_const(r, $urandom);
      repeat (40)
      begin
         kind = $urandom % 6;
         rd   = 4 + $urandom % 8;
         case (kind)
            0: emit(enc($urandom, 0, $urandom, rd, $urandom % 12,
                        {4'($urandom % 12), 8'h00, 4'($urandom % 9)}));
            1: emit(enc($urandom, 1, $urandom, rd, $urandom % 12, $urandom));
            2: emit(enc($urandom, 7, $urandom, rd, 1 + $urandom % 3, $urandom % 4));
            3: emit(enc($urandom, 5, 0, rd, 1 + $urandom % 3, (4 + $urandom % 8) << 12));
            4: emit(enc($urandom, 6, $urandom, $urandom % 12, 1 + $urandom % 3, $urandom % 4));
            default: emit(enc($urandom, 3, 0, 0, 0, 0));
         endcase
      end
      halt();
      run_test("random program", wp + 2);

      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (n_fail == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/cpu_sched.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_core.sv
verilog/cpu_mem.sv
verilog/cpu_system.sv
bench/cpu_chk.sv
bench/cpu_tb.sv
